//--- lc3_params.svh
`ifndef LC3_PARAMS_SVH
`define LC3_PARAMS_SVH

////////////////////////////////////////////////////////////////////////////
// Core sizing
////////////////////////////////////////////////////////////////////////////

// Data and address width
`define LC3_WORD_W 16

// General purpose registers R0..R7
`define LC3_REG_COUNT 8

// Instruction queue entries as a power of two
`define LC3_QUEUE_DEPTH 4

// First instruction fetched after reset
`define LC3_RESET_PC 16'h0001

`endif

//--- lc3_pkg.sv
`include "lc3_params.svh"

package lc3_pkg;

    typedef logic [`LC3_WORD_W-1:0] word_t;                 // Machine word
    typedef logic [$clog2(`LC3_REG_COUNT)-1:0] regIdx_t;    // Register number

    // LC-3 opcodes in field [15:12] of the instruction
    typedef enum logic [3:0] {
        opBr   = 4'h0,
        opAdd  = 4'h1,
        opLd   = 4'h2,
        opSt   = 4'h3,
        opJsr  = 4'h4,
        opAnd  = 4'h5,
        opLdr  = 4'h6,
        opStr  = 4'h7,
        opRti  = 4'h8,
        opNot  = 4'h9,
        opLdi  = 4'hA,
        opSti  = 4'hB,
        opJmp  = 4'hC,
        opRes  = 4'hD,
        opLea  = 4'hE,
        opTrap = 4'hF
    } opcode_t;

    typedef enum logic [1:0] {
        aluAdd   = 2'b00,
        aluAnd   = 2'b01,
        aluNot   = 2'b10,
        aluPassA = 2'b11        // Operand A unchanged
    } aluOp_t;

    typedef struct packed {
        logic n;
        logic z;
        logic p;
    } cc_t;

    typedef struct packed {
        word_t pc;              // Address the word was fetched from
        word_t instr;
    } fetchEntry_t;

    typedef struct packed {
        logic  valid;           // One-cycle strobe
        word_t target;
    } redirect_t;

    typedef struct packed {
        logic  rd;
        logic  wr;
        word_t addr;
        word_t wdata;
    } dataReq_t;

    typedef struct packed {
        logic    en;
        regIdx_t dest;
        word_t   value;
    } regWrite_t;

endpackage

//--- lc3_fetch.sv
`timescale 1ns/10ps
`include "lc3_params.svh"

module lc3_fetch (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                hasRoom,
    input  lc3_pkg::redirect_t  redirect,
    output logic                imemRd,
    output lc3_pkg::word_t      imemAddr,
    input  lc3_pkg::word_t      imemData,
    output logic                push,
    output lc3_pkg::fetchEntry_t entry
);
    import lc3_pkg::*;

    word_t fetchPc;         // Address of the next read
    logic  pending;         // A read is in flight
    word_t pendPc;          // Address of the read in flight

    ////////////////////////////////////////////////////////////////////////////
    // Read request
    ////////////////////////////////////////////////////////////////////////////

    // Idle during reset and while a redirect makes fetchPc stale
    assign imemRd   = rst_n && hasRoom && !redirect.valid;
    assign imemAddr = fetchPc;

    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            fetchPc <= `LC3_RESET_PC;
            pending <= 1'b0;
        end else if (redirect.valid) begin
            fetchPc <= redirect.target;     // Restart at branch target
            pending <= 1'b0;                // Drop the read in flight
        end else begin
            pending <= imemRd;
            if (imemRd) begin
                fetchPc <= fetchPc + 1'b1;
            end
        end
    end

    // Address travels alongside the read
    always_ff @(posedge clk) begin
        if (imemRd) begin
            pendPc <= fetchPc;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Push returned word
    ////////////////////////////////////////////////////////////////////////////

    // A redirect in the return cycle also kills the word
    assign push        = pending && !redirect.valid;
    assign entry.pc    = pendPc;
    assign entry.instr = imemData;

endmodule

//--- lc3_inst_queue.sv
`timescale 1ns/10ps
`include "lc3_params.svh"

module lc3_inst_queue #(
    parameter int Depth = `LC3_QUEUE_DEPTH
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 push,
    input  lc3_pkg::fetchEntry_t entry,
    input  logic                 pop,
    input  logic                 flush,
    output lc3_pkg::fetchEntry_t head,
    output logic                 notEmpty,
    output logic                 hasRoom
);
    import lc3_pkg::*;

    localparam int PtrW = $clog2(Depth);

    fetchEntry_t     mem [Depth];
    logic [PtrW-1:0] wrPtr;
    logic [PtrW-1:0] rdPtr;
    logic [PtrW:0]   count;         // Entries held from 0 to Depth
    logic            doPop;

    assign doPop = pop && notEmpty;

    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else if (flush) begin
            wrPtr <= '0;                    // Discard everything fetched
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wrPtr <= wrPtr + 1'b1;      // Wraps at Depth
            end
            if (doPop) begin
                rdPtr <= rdPtr + 1'b1;
            end
            count <= count + push - doPop;
        end
    end

    always_ff @(posedge clk) begin
        if (push && !flush) begin
            mem[wrPtr] <= entry;
        end
    end

    assign head     = mem[rdPtr];
    assign notEmpty = (count != '0);
    assign hasRoom  = (count <= (PtrW+1)'(Depth - 2));   // Two slots free

endmodule

//--- lc3_reg_file.sv
`timescale 1ns/10ps
`include "lc3_params.svh"

module lc3_reg_file (
    input  logic               clk,
    input  logic               rst_n,
    input  lc3_pkg::regIdx_t   rdIdxA,
    input  lc3_pkg::regIdx_t   rdIdxB,
    output lc3_pkg::word_t     rdA,
    output lc3_pkg::word_t     rdB,
    input  lc3_pkg::regWrite_t wr
);
    import lc3_pkg::*;

    word_t regs [`LC3_REG_COUNT];

    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `LC3_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wr.en) begin
            regs[wr.dest] <= wr.value;
        end
    end

    // Combinational reads see the old value during a write
    assign rdA = regs[rdIdxA];
    assign rdB = regs[rdIdxB];

endmodule

//--- lc3_execute.sv
`timescale 1ns/10ps
`include "lc3_params.svh"

module lc3_execute (
    input  logic                 clk,
    input  logic                 rst_n,
    input  lc3_pkg::fetchEntry_t head,
    input  logic                 notEmpty,
    output logic                 pop,
    output lc3_pkg::redirect_t   redirect,
    output lc3_pkg::dataReq_t    dmemReq,
    input  lc3_pkg::word_t       dmemRdata,
    output lc3_pkg::regWrite_t   regWrite
);
    import lc3_pkg::*;

    word_t   instr;
    word_t   nextPc;            // PC seen by the instruction
    opcode_t opcode;
    regIdx_t rdIdxA;
    regIdx_t rdIdxB;
    word_t   regA;
    word_t   regB;
    word_t   imm5;
    word_t   off6;
    word_t   off9;
    word_t   off11;
    word_t   addrBase;
    word_t   addrOff;
    word_t   effAddr;
    aluOp_t  aluOp;
    word_t   aluB;
    word_t   aluOut;
    logic    brTaken;
    logic    setCc;
    logic    loadPhase;         // Second cycle of LD and LDR
    cc_t     cc;
    cc_t     ccNext;

    assign instr  = head.instr;
    assign nextPc = head.pc + 1'b1;
    assign opcode = opcode_t'(instr[15:12]);

    // Port B carries store data for ST and STR
    assign rdIdxA = instr[8:6];
    assign rdIdxB = (opcode == opSt || opcode == opStr) ? instr[11:9] : instr[2:0];

    lc3_reg_file iRegFile (
        .clk    (clk),
        .rst_n  (rst_n),
        .rdIdxA (rdIdxA),
        .rdIdxB (rdIdxB),
        .rdA    (regA),
        .rdB    (regB),
        .wr     (regWrite)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Offsets and address adder
    ////////////////////////////////////////////////////////////////////////////

    assign imm5  = {{(`LC3_WORD_W-5){instr[4]}}, instr[4:0]};
    assign off6  = {{(`LC3_WORD_W-6){instr[5]}}, instr[5:0]};
    assign off9  = {{(`LC3_WORD_W-9){instr[8]}}, instr[8:0]};
    assign off11 = {{(`LC3_WORD_W-11){instr[10]}}, instr[10:0]};

    always_comb begin
        addrBase = nextPc;
        addrOff  = off9;                            // LD, ST, LEA, BR
        case (opcode)
            opLdr, opStr: begin
                addrBase = regA;
                addrOff  = off6;
            end
            opJmp: begin
                addrBase = regA;                    // Also RET via R7
                addrOff  = '0;
            end
            opJsr: begin
                addrBase = instr[11] ? nextPc : regA;   // JSR or JSRR
                addrOff  = instr[11] ? off11 : '0;
            end
            default: ;
        endcase
    end

    assign effAddr = addrBase + addrOff;

    ////////////////////////////////////////////////////////////////////////////
    // ALU and condition codes
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        case (opcode)
            opAdd:   aluOp = aluAdd;
            opAnd:   aluOp = aluAnd;
            opNot:   aluOp = aluNot;
            default: aluOp = aluPassA;
        endcase
    end

    assign aluB = instr[5] ? imm5 : regB;

    always_comb begin
        case (aluOp)
            aluAdd:  aluOut = regA + aluB;
            aluAnd:  aluOut = regA & aluB;
            aluNot:  aluOut = ~regA;
            default: aluOut = regA;
        endcase
    end

    assign brTaken = (instr[11] & cc.n) | (instr[10] & cc.z) | (instr[9] & cc.p);

    assign ccNext.n = regWrite.value[`LC3_WORD_W-1];
    assign ccNext.z = (regWrite.value == '0);
    assign ccNext.p = !ccNext.n && !ccNext.z;

    ////////////////////////////////////////////////////////////////////////////
    // Control
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        pop             = 1'b0;
        setCc           = 1'b0;
        redirect        = '0;
        redirect.target = effAddr;
        dmemReq         = '0;
        dmemReq.addr    = effAddr;
        dmemReq.wdata   = regB;
        regWrite        = '0;
        regWrite.dest   = instr[11:9];
        regWrite.value  = aluOut;
        if (notEmpty) begin
            case (opcode)
                opAdd, opAnd, opNot: begin
                    regWrite.en = 1'b1;
                    setCc       = 1'b1;
                    pop         = 1'b1;
                end
                opLea: begin
                    regWrite.en    = 1'b1;
                    regWrite.value = effAddr;
                    setCc          = 1'b1;
                    pop            = 1'b1;
                end
                opLd, opLdr: begin
                    if (!loadPhase) begin
                        dmemReq.rd = 1'b1;          // Data back next cycle
                    end else begin
                        regWrite.en    = 1'b1;
                        regWrite.value = dmemRdata;
                        setCc          = 1'b1;
                        pop            = 1'b1;
                    end
                end
                opSt, opStr: begin
                    dmemReq.wr = 1'b1;
                    pop        = 1'b1;
                end
                opBr: begin
                    redirect.valid = brTaken;       // Untaken just pops
                    pop            = 1'b1;
                end
                opJmp: begin
                    redirect.valid = 1'b1;
                    pop            = 1'b1;
                end
                opJsr: begin
                    regWrite.en    = 1'b1;
                    regWrite.dest  = regIdx_t'(`LC3_REG_COUNT - 1);    // R7 link
                    regWrite.value = nextPc;
                    redirect.valid = 1'b1;
                    pop            = 1'b1;
                end
                default: pop = 1'b1;                // Unsupported ops skip
            endcase
        end
    end

    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            loadPhase <= 1'b0;
            cc        <= '0;
        end else begin
            loadPhase <= dmemReq.rd;
            if (setCc) begin
                cc <= ccNext;
            end
        end
    end

endmodule

//--- lc3_core.sv
`timescale 1ns/10ps
`include "lc3_params.svh"

module lc3_core (
    input  logic               clk,
    input  logic               rst_n,
    output logic               imemRd,
    output lc3_pkg::word_t     imemAddr,
    input  lc3_pkg::word_t     imemData,
    output lc3_pkg::dataReq_t  dmemReq,
    input  lc3_pkg::word_t     dmemRdata,
    output lc3_pkg::regWrite_t regWrite
);
    import lc3_pkg::*;

    logic        push;
    fetchEntry_t entry;
    logic        hasRoom;
    fetchEntry_t head;
    logic        notEmpty;
    logic        pop;
    redirect_t   redirect;      // Flushes queue and restarts fetch

    lc3_fetch iFetch (
        .clk      (clk),
        .rst_n    (rst_n),
        .hasRoom  (hasRoom),
        .redirect (redirect),
        .imemRd   (imemRd),
        .imemAddr (imemAddr),
        .imemData (imemData),
        .push     (push),
        .entry    (entry)
    );

    lc3_inst_queue #(
        .Depth (`LC3_QUEUE_DEPTH)
    ) iQueue (
        .clk      (clk),
        .rst_n    (rst_n),
        .push     (push),
        .entry    (entry),
        .pop      (pop),
        .flush    (redirect.valid),
        .head     (head),
        .notEmpty (notEmpty),
        .hasRoom  (hasRoom)
    );

    lc3_execute iExecute (
        .clk       (clk),
        .rst_n     (rst_n),
        .head      (head),
        .notEmpty  (notEmpty),
        .pop       (pop),
        .redirect  (redirect),
        .dmemReq   (dmemReq),
        .dmemRdata (dmemRdata),
        .regWrite  (regWrite)
    );

endmodule

//--- lc3_chk.sv
`timescale 1ns/10ps

module lc3_chk (
    input logic               clk,
    input logic               rst_n,
    input logic               imemRd,
    input lc3_pkg::dataReq_t  dmemReq,
    input lc3_pkg::regWrite_t regWrite
);
    int failCount = 0;          // Failed assertions so far

    // Read and write share one data port
    rdWrExclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(dmemReq.rd && dmemReq.wr))
        else begin
            $error("Data read and write requested in the same cycle");
            failCount++;
        end

    noWriteInReset: assert property (@(posedge clk) !rst_n |-> !regWrite.en)
        else begin
            $error("Register write-back during reset");
            failCount++;
        end

    noFetchInReset: assert property (@(posedge clk) !rst_n |-> !imemRd)
        else begin
            $error("Instruction read issued during reset");
            failCount++;
        end

    // Load data cycle never overlaps a store
    noWrAfterRd: assert property (@(posedge clk) disable iff (!rst_n)
        dmemReq.rd |=> !dmemReq.wr)
        else begin
            $error("Data write in the cycle after a data read");
            failCount++;
        end

    // LD and LDR write back in the cycle after their read
    loadWriteBack: assert property (@(posedge clk) disable iff (!rst_n)
        dmemReq.rd |=> regWrite.en)
        else begin
            $error("Data read not followed by a register write-back");
            failCount++;
        end

endmodule

//--- lc3_monitor.sv
`timescale 1ns/10ps

module lc3_monitor #(
    parameter int MaxEvents = 64
) (
    input  logic               clk,
    input  logic               rst_n,
    input  lc3_pkg::regWrite_t regWrite,
    input  lc3_pkg::dataReq_t  dmemReq,
    input  int                 expCount,
    input  logic [7:0]         expKind [MaxEvents],
    input  lc3_pkg::word_t     expA [MaxEvents],
    input  lc3_pkg::word_t     expB [MaxEvents],
    output int                 seen,
    output int                 mismatches,
    output int                 extras
);
    import lc3_pkg::*;

    function automatic string kindName(input logic [7:0] kind);
        return (kind == "W") ? "register write" : "store";
    endfunction

    task automatic compareField(input string name, input word_t expVal, input word_t gotVal);
        if (gotVal !== expVal) begin
            mismatches++;
            $display("MISMATCH %s expected %h got %h at %0t", name, expVal, gotVal, $time);
        end
    endtask

    // Each event is matched in order against the next trace entry
    task automatic matchEvent(input logic [7:0] kind, input word_t a, input word_t b);
        if (seen >= expCount) begin
            extras++;
            $display("Extra %s after the end of the trace (%h, %h) at %0t",
                     kindName(kind), a, b, $time);
        end else begin
            if (expKind[seen] != kind) begin
                mismatches++;
                $display("Event %0d should be a %s but the core made a %s at %0t",
                         seen, kindName(expKind[seen]), kindName(kind), $time);
            end else if (kind == "W") begin
                compareField("regWrite.dest", expA[seen], a);
                compareField("regWrite.value", expB[seen], b);
            end else begin
                compareField("dmemReq.addr", expA[seen], a);
                compareField("dmemReq.wdata", expB[seen], b);
            end
            seen++;
        end
    endtask

    // Sampled on the falling edge where strobes are settled
    always @(negedge clk) begin
        if (!rst_n) begin
            seen       = 0;
            mismatches = 0;
            extras     = 0;
        end else begin
            if (regWrite.en) begin
                matchEvent("W", word_t'(regWrite.dest), regWrite.value);
            end
            if (dmemReq.wr) begin
                matchEvent("S", dmemReq.addr, dmemReq.wdata);
            end
        end
    end

endmodule

//--- lc3_tb.sv
`timescale 1ns/10ps
`include "lc3_params.svh"

module lc3_clkGen (
    output logic clk,
    output logic rst_n
);
    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;                 // 100 ns period
    end

    initial begin
        rst_n = 1'b0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;                          // Released on the 4th edge
    end
endmodule

module lc3_tb;
    import lc3_pkg::*;

    localparam int    MaxEvents    = 64;
    localparam int    SettleCycles = 16;        // Window for late extra events
    localparam string StimFile     = "lc3_stim.txt";

    logic      clk;
    logic      rst_n;
    logic      imemRd;
    word_t     imemAddr;
    word_t     imemData;
    dataReq_t  dmemReq;
    word_t     dmemRdata;
    regWrite_t regWrite;

    word_t      imem [1 << `LC3_WORD_W];
    word_t      dmem [1 << `LC3_WORD_W];
    logic [7:0] expKind [MaxEvents];            // Event tag W or S
    word_t      expA [MaxEvents];               // Dest or store address
    word_t      expB [MaxEvents];               // Value or store data
    int         expCount   = 0;
    int         numInstr   = 0;
    int         stimErrors = 0;
    logic       stimLoaded = 1'b0;
    int         seen;
    int         mismatches;
    int         extras;

    lc3_clkGen iClkGen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    lc3_core UUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .imemRd    (imemRd),
        .imemAddr  (imemAddr),
        .imemData  (imemData),
        .dmemReq   (dmemReq),
        .dmemRdata (dmemRdata),
        .regWrite  (regWrite)
    );

    bind lc3_core lc3_chk iChk (
        .clk      (clk),
        .rst_n    (rst_n),
        .imemRd   (imemRd),
        .dmemReq  (dmemReq),
        .regWrite (regWrite)
    );

    lc3_monitor #(
        .MaxEvents (MaxEvents)
    ) iMonitor (
        .clk        (clk),
        .rst_n      (rst_n),
        .regWrite   (regWrite),
        .dmemReq    (dmemReq),
        .expCount   (expCount),
        .expKind    (expKind),
        .expA       (expA),
        .expB       (expB),
        .seen       (seen),
        .mismatches (mismatches),
        .extras     (extras)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Memory models with one cycle read latency
    ////////////////////////////////////////////////////////////////////////////

    always @(posedge clk) begin
        if (imemRd) begin
            imemData <= imem[imemAddr];
        end
        if (dmemReq.rd) begin
            dmemRdata <= dmem[dmemReq.addr];
        end
        if (dmemReq.wr) begin
            dmem[dmemReq.addr] <= dmemReq.wdata;
        end
    end

    // Zero words decode as a BR that never branches
    task automatic clearMemories();
        for (int i = 0; i < (1 << `LC3_WORD_W); i++) begin
            imem[i] = '0;
            dmem[i] <= '0;
        end
    endtask

    task automatic loadStim();
        int         fd;
        int         n;
        string      line;
        logic [7:0] tag;
        word_t      a;
        word_t      b;
        fd = $fopen(StimFile, "r");
        if (fd == 0) begin
            stimErrors++;
            $display("Cannot open stimulus file %s", StimFile);
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            n    = $fgets(line, fd);
            n    = $sscanf(line, "%c %h %h", tag, a, b);
            if (n == 3 && tag != "#") begin
                case (tag)
                    "I": begin
                        imem[a] = b;
                        numInstr++;
                    end
                    "D": dmem[a] <= b;
                    "W", "S": begin
                        if (expCount < MaxEvents) begin
                            expKind[expCount] = tag;
                            expA[expCount]    = a;
                            expB[expCount]    = b;
                            expCount++;
                        end else begin
                            stimErrors++;
                            $display("Stimulus file holds more events than the trace can store");
                        end
                    end
                    default: begin
                        stimErrors++;
                        $display("Stimulus line with unknown tag: %s", line);
                    end
                endcase
            end
        end
        $fclose(fd);
        if (expCount == 0) begin
            stimErrors++;
            $display("Stimulus file has no expected events");
        end
    endtask

    task automatic printSummary(input int missing);
        $display("Errors: %0d mismatch, %0d extra, %0d missing, %0d stimulus, %0d assertion",
                 mismatches, extras, missing, stimErrors, UUT.iChk.failCount);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Run control and watchdog
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        int missing;
        imemData  <= '0;
        dmemRdata <= '0;
        clearMemories();
        loadStim();
        stimLoaded = 1'b1;
        wait (rst_n === 1'b1);
        wait (seen >= expCount);                // Program idles in its final loop
        repeat (SettleCycles) @(posedge clk);
        missing = expCount - seen;
        printSummary(missing);
        if (mismatches + extras + missing + stimErrors + UUT.iChk.failCount == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    initial begin
        int limitCycles;
        wait (stimLoaded);
        limitCycles = (numInstr + expCount + 20) * 4;
        repeat (limitCycles) @(posedge clk);
        $display("Timeout after %0d cycles, %0d of %0d expected events never appeared",
                 limitCycles, expCount - seen, expCount);
        printSummary(expCount - seen);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

//--- lc3_stim.txt
# Columns: tag, hex field, hex field. I addr instr, D addr data, W dest value, S addr data
# W and S lines form the expected write-back and store trace, in program order
I 0001 5020 AND R0,R0,#0
I 0002 1225 ADD R1,R0,#5
I 0003 147D ADD R2,R1,#-3
I 0004 1642 ADD R3,R1,R2
I 0005 58C2 AND R4,R3,R2
I 0006 5AFE AND R5,R3,#-2
I 0007 9CFF NOT R6,R3
I 0008 0205 BRp not taken
I 0009 0405 BRz not taken
I 000A 0801 BRn taken to 000C
I 000B 1021 ADD R0,R0,#1 skipped
I 000C E023 LEA R0,0030
I 000D 2222 LD R1,0030
I 000E 6401 LDR R2,R0,#1
I 000F 0401 BRz taken to 0011
I 0010 16E1 ADD R3,R3,#1 skipped
I 0011 3A20 ST R5,0032
I 0012 7C3F STR R6,R0,#-1
I 0013 6802 LDR R4,R0,#2
I 0014 0C01 BRnz not taken
I 0015 4804 JSR 001A
I 0016 E603 LEA R3,001A
I 0017 40C0 JSRR R3
I 0018 0FFF BRnzp to self
I 001A 1B7F ADD R5,R5,#-1
I 001B C1C0 RET
D 0030 8001
D 0031 0000
D 0032 AAAA overwritten by ST
W 0 0000
W 1 0005
W 2 0002
W 3 0007
W 4 0002
W 5 0006
W 6 FFF8
W 0 0030
W 1 8001
W 2 0000
S 0032 0006
S 002F FFF8
W 4 0006
W 7 0016
W 5 0005
W 3 001A
W 7 0018
W 5 0004

//--- all.f
+incdir+.
lc3_pkg.sv
lc3_fetch.sv
lc3_inst_queue.sv
lc3_reg_file.sv
lc3_execute.sv
lc3_core.sv
lc3_chk.sv
lc3_monitor.sv
lc3_tb.sv

//--- Makefile
# Verilator simulation of the LC-3 core testbench

VERILATOR ?= verilator
TOP       ?= lc3_tb
FILELIST  ?= all.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SIMFLAGS  ?= +verilator+error+limit+1000
FAIL_MSG  ?= TEST RESULT: FAIL
PASS_MSG  ?= TEST RESULT: PASS

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)
	./$(OBJDIR)/V$(TOP) $(SIMFLAGS) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG) || ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJDIR) $(LOG)
